// File: src/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath word.
`define DATA_WIDTH 32

// Register index and register file depth.
`define REG_ADDR_WIDTH 5
`define NUM_REGS 32

`endif

// File: src/cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

    // R-format view of the instruction word.
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                 shamt;
        logic [5:0]                 funct;
    } rFormat;

    // I-format view of the same word.
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [15:0]                imm16;
    } iFormat;

    typedef union packed {
        rFormat rFields;
        iFormat iFields;
    } instrWord;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluLui
    } aluOpE;

    typedef enum logic [2:0] {
        hiLoNone, hiLoMult, hiLoMadd, hiLoMthi, hiLoMtlo, hiLoMfhi, hiLoMflo
    } hiLoOpE;

    typedef struct packed {
        logic                       regWrite;  // Already qualified by a nonzero dest.
        logic                       aluSrcImm;
        aluOpE                      aluOp;
        hiLoOpE                     hiLoOp;
        logic [`REG_ADDR_WIDTH-1:0] destReg;   // rd or rt, picked in decode.
    } ctrlBundle;

    typedef struct packed {
        logic                   valid;
        ctrlBundle              ctrl;
        logic [`DATA_WIDTH-1:0] readData1;
        logic [`DATA_WIDTH-1:0] readData2;
        logic [`DATA_WIDTH-1:0] extImm;
        logic [4:0]             shamt;
    } idExBundle;

    typedef struct packed {
        logic                       valid;
        logic [`REG_ADDR_WIDTH-1:0] destReg;
        logic [`DATA_WIDTH-1:0]     data;
    } wbBundle;

endpackage

// File: src/regFile.sv
`include "cpu_defines.svh"

module regFile (
    input  logic                       Clk,
    input  logic                       rstN,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddr2,
    output logic [`DATA_WIDTH-1:0]     readData1,
    output logic [`DATA_WIDTH-1:0]     readData2,
    input  cpuPkg::wbBundle            wb
);
    import cpuPkg::*;

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wb.valid)
            regs[wb.destReg] <= wb.data;
    end

    // Write-first bypass, $0 reads as zero.
    always_comb
    begin
        readData1 = regs[readAddr1];
        readData2 = regs[readAddr2];
        if (wb.valid && wb.destReg == readAddr1)
            readData1 = wb.data;
        if (wb.valid && wb.destReg == readAddr2)
            readData2 = wb.data;
        if (readAddr1 == '0)
            readData1 = '0;
        if (readAddr2 == '0)
            readData2 = '0;
    end

    // Decode is expected to drop every write to $0.
    noWriteToZero: assert property (@(posedge Clk) disable iff (!rstN)
        wb.valid |-> wb.destReg != '0);

endmodule

// File: src/decodeStage.sv
`include "cpu_defines.svh"

module decodeStage (
    input  logic                       instrValid,
    input  cpuPkg::instrWord           instr,
    output logic [`REG_ADDR_WIDTH-1:0] readAddr1,
    output logic [`REG_ADDR_WIDTH-1:0] readAddr2,
    input  logic [`DATA_WIDTH-1:0]     readData1,
    input  logic [`DATA_WIDTH-1:0]     readData2,
    output cpuPkg::idExBundle          decoded
);
    import cpuPkg::*;

    localparam logic [5:0] opSpecial  = 6'h00;
    localparam logic [5:0] opSpecial2 = 6'h1C;
    localparam logic [5:0] opAddi     = 6'h08;
    localparam logic [5:0] opAndi     = 6'h0C;
    localparam logic [5:0] opOri      = 6'h0D;
    localparam logic [5:0] opLui      = 6'h0F;

    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnMfhi = 6'h10;
    localparam logic [5:0] fnMthi = 6'h11;
    localparam logic [5:0] fnMflo = 6'h12;
    localparam logic [5:0] fnMtlo = 6'h13;
    localparam logic [5:0] fnMult = 6'h18;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2A;
    localparam logic [5:0] fnMadd = 6'h00;  // Under SPECIAL2.

    ctrlBundle              ctrl;
    logic                   writesReg;
    logic [`DATA_WIDTH-1:0] extImm;

    // rs and rt sit at the same place in both views.
    assign readAddr1 = instr.rFields.rs;
    assign readAddr2 = instr.rFields.rt;

    always_comb
    begin
        ctrl           = '0;
        ctrl.aluOp     = aluAdd;
        ctrl.hiLoOp    = hiLoNone;
        ctrl.destReg   = instr.rFields.rd;
        writesReg      = 1'b0;
        extImm         = {{16{instr.iFields.imm16[15]}}, instr.iFields.imm16};

        case (instr.rFields.opcode)
            opSpecial:
            begin
                writesReg = 1'b1;
                case (instr.rFields.funct)
                    fnAdd:  ctrl.aluOp = aluAdd;
                    fnSub:  ctrl.aluOp = aluSub;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnXor:  ctrl.aluOp = aluXor;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSll:  ctrl.aluOp = aluSll;
                    fnMfhi: ctrl.hiLoOp = hiLoMfhi;
                    fnMflo: ctrl.hiLoOp = hiLoMflo;
                    fnMult:
                    begin
                        ctrl.hiLoOp = hiLoMult;
                        writesReg   = 1'b0;
                    end
                    fnMthi:
                    begin
                        ctrl.hiLoOp = hiLoMthi;
                        writesReg   = 1'b0;
                    end
                    fnMtlo:
                    begin
                        ctrl.hiLoOp = hiLoMtlo;
                        writesReg   = 1'b0;
                    end
                    default: writesReg = 1'b0;  // Unknown funct is a no-op.
                endcase
            end
            opSpecial2:
                if (instr.rFields.funct == fnMadd)
                    ctrl.hiLoOp = hiLoMadd;
            opAddi, opAndi, opOri, opLui:
            begin
                // I view from here on.
                writesReg      = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.destReg   = instr.iFields.rt;
                if (instr.iFields.opcode != opAddi)
                    extImm = {16'h0000, instr.iFields.imm16};
                case (instr.iFields.opcode)
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opLui:   ctrl.aluOp = aluLui;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            default: ;
        endcase

        ctrl.regWrite = instrValid && writesReg && ctrl.destReg != '0;
    end

    assign decoded.valid     = instrValid;
    assign decoded.ctrl      = ctrl;
    assign decoded.readData1 = readData1;
    assign decoded.readData2 = readData2;
    assign decoded.extImm    = extImm;
    assign decoded.shamt     = instr.rFields.shamt;

endmodule

// File: src/idExPipeReg.sv
module idExPipeReg (
    input  logic              Clk,
    input  logic              rstN,
    input  cpuPkg::idExBundle decodedIn,
    output cpuPkg::idExBundle decodedOut
);
    import cpuPkg::*;

    // Operands are payload and hold through reset.
    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            decodedOut.valid <= 1'b0;
            decodedOut.ctrl  <= '0;
        end
        else
            decodedOut <= decodedIn;
    end

    // A register write only travels with a real instruction.
    writeNeedsValid: assert property (@(posedge Clk) disable iff (!rstN)
        decodedOut.ctrl.regWrite |-> decodedOut.valid);

endmodule

// File: src/executeStage.sv
`include "cpu_defines.svh"

module executeStage (
    input  logic              Clk,
    input  logic              rstN,
    input  cpuPkg::idExBundle decoded,
    output cpuPkg::wbBundle   wb
);
    import cpuPkg::*;

    logic [`DATA_WIDTH-1:0]   opA;
    logic [`DATA_WIDTH-1:0]   opB;
    logic [`DATA_WIDTH-1:0]   aluResult;
    logic [`DATA_WIDTH-1:0]   result;
    logic [`DATA_WIDTH-1:0]   hi;
    logic [`DATA_WIDTH-1:0]   lo;
    logic [2*`DATA_WIDTH-1:0] product;
    logic [2*`DATA_WIDTH-1:0] accum;

    assign opA = decoded.readData1;
    assign opB = decoded.ctrl.aluSrcImm ? decoded.extImm : decoded.readData2;

    always_comb
    begin
        case (decoded.ctrl.aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluXor:  aluResult = opA ^ opB;
            aluSlt:  aluResult = {{(`DATA_WIDTH-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSll:  aluResult = opB << decoded.shamt;
            aluLui:  aluResult = {opB[15:0], 16'h0000};
            default: aluResult = opA + opB;
        endcase
    end

    // Signed 64-bit product, both operands widened first.
    assign product = $signed({{`DATA_WIDTH{opA[`DATA_WIDTH-1]}}, opA})
                   * $signed({{`DATA_WIDTH{decoded.readData2[`DATA_WIDTH-1]}},
                               decoded.readData2});
    assign accum   = {hi, lo} + product;

    always_comb
    begin
        case (decoded.ctrl.hiLoOp)
            hiLoMfhi: result = hi;
            hiLoMflo: result = lo;
            default:  result = aluResult;
        endcase
    end

    // Hi/Lo update at the end of execute.
    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            hi <= '0;
            lo <= '0;
        end
        else if (decoded.valid)
        begin
            case (decoded.ctrl.hiLoOp)
                hiLoMult: {hi, lo} <= product;
                hiLoMadd: {hi, lo} <= accum;
                hiLoMthi: hi <= opA;
                hiLoMtlo: lo <= opA;
                default:  ;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            wb.valid   <= 1'b0;
            wb.destReg <= '0;
        end
        else
        begin
            wb.valid   <= decoded.valid && decoded.ctrl.regWrite;
            wb.destReg <= decoded.ctrl.destReg;
            wb.data    <= result;  // No reset on data.
        end
    end

    wbDestNonZero: assert property (@(posedge Clk) disable iff (!rstN)
        wb.valid |-> wb.destReg != '0);

    // Operands reach here from the register file one cycle earlier.
    wbDataKnown: assert property (@(posedge Clk) disable iff (!rstN)
        wb.valid |-> !$isunknown(wb.data));

endmodule

// File: src/execPipeTop.sv
`include "cpu_defines.svh"

module execPipeTop (
    input  logic                       Clk,
    input  logic                       rstN,
    input  logic                       instrValid,
    input  cpuPkg::instrWord           instr,
    output logic                       wbValid,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg,
    output logic [`DATA_WIDTH-1:0]     wbData
);
    import cpuPkg::*;

    logic [`REG_ADDR_WIDTH-1:0] readAddr1;
    logic [`REG_ADDR_WIDTH-1:0] readAddr2;
    logic [`DATA_WIDTH-1:0]     readData1;
    logic [`DATA_WIDTH-1:0]     readData2;
    idExBundle                  decoded;
    idExBundle                  idExOut;
    wbBundle                    wb;

    regFile regFile_inst (
        .Clk(Clk), .rstN(rstN),
        .readAddr1(readAddr1), .readAddr2(readAddr2),
        .readData1(readData1), .readData2(readData2),
        .wb(wb)
    );

    decodeStage decodeStage_inst (
        .instrValid(instrValid), .instr(instr),
        .readAddr1(readAddr1), .readAddr2(readAddr2),
        .readData1(readData1), .readData2(readData2),
        .decoded(decoded)
    );

    idExPipeReg idExPipeReg_inst (.Clk(Clk), .rstN(rstN), .decodedIn(decoded), .decodedOut(idExOut));

    executeStage executeStage_inst (.Clk(Clk), .rstN(rstN), .decoded(idExOut), .wb(wb));

    // Writeback goes out as well as back into the register file.
    assign wbValid = wb.valid;
    assign wbReg   = wb.destReg;
    assign wbData  = wb.data;

endmodule

// File: testbench/execPipeTb.sv
`include "cpu_defines.svh"

module execPipeTb;
    import cpuPkg::*;

    typedef struct packed {
        int                         issue;
        logic                       writes;
        logic [`REG_ADDR_WIDTH-1:0] destReg;
        logic [`DATA_WIDTH-1:0]     data;
    } expEntry;

    logic                       Clk;
    logic                       rstN;
    logic                       instrValid;
    instrWord                   instr;
    logic                       wbValid;
    logic [`REG_ADDR_WIDTH-1:0] wbReg;
    logic [`DATA_WIDTH-1:0]     wbData;

    logic [`DATA_WIDTH-1:0] refReg [`NUM_REGS];  // Reference model state.
    logic [`DATA_WIDTH-1:0] refHi;
    logic [`DATA_WIDTH-1:0] refLo;
    expEntry                expQ [$];
    expEntry                expHead;
    logic                   expDue = 1'b0;
    int                     cycle = 0;
    int                     errors = 0;
    int                     tests = 0;
    int                     failedTests = 0;

    execPipeTop execPipeTop_inst (
        .Clk(Clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    always #5 Clk = ~Clk;

    // Queue head is due two cycles after its issue cycle.
    always @(posedge Clk)
    begin
        if (expQ.size() > 0 && expQ[0].issue + 2 == cycle)
            expQ.pop_front();
        expDue <= expQ.size() > 0 && expQ[0].issue + 2 == cycle + 1;
        if (expQ.size() > 0)
            expHead <= expQ[0];
        cycle <= cycle + 1;
    end

    task automatic flagError(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    wbMatch: assert property (@(posedge Clk) disable iff (!rstN)
        expDue && expHead.writes |-> wbValid && wbReg == expHead.destReg
                                     && wbData == expHead.data)
        else flagError($sformatf("wb reg %0d data %h, expected reg %0d data %h",
                       $sampled(wbReg), $sampled(wbData),
                       $sampled(expHead.destReg), $sampled(expHead.data)));

    noExtraWb: assert property (@(posedge Clk) disable iff (!rstN)
        !(expDue && expHead.writes) |-> !wbValid)
        else flagError($sformatf("unexpected wbValid for reg %0d", $sampled(wbReg)));

    quietInReset: assert property (@(posedge Clk) !rstN && cycle > 0 |-> !wbValid)
        else flagError("wbValid high during reset");

    function automatic logic [4:0] srcReg();
        return 5'(1 + $urandom % 15);
    endfunction

    function automatic logic [4:0] dstReg();
        return 5'(16 + $urandom % 16);
    endfunction

    function automatic logic [5:0] aluFunct(input int k);
        case (k % 7)
            0:       return 6'h20;  // add
            1:       return 6'h22;  // sub
            2:       return 6'h24;  // and
            3:       return 6'h25;  // or
            4:       return 6'h26;  // xor
            5:       return 6'h2A;  // slt
            default: return 6'h00;  // sll
        endcase
    endfunction

    // Drive one word for a cycle and queue what it should write back.
    task automatic issueWord(input instrWord w, input logic writes,
                             input logic [4:0] dest, input logic [31:0] data);
        expQ.push_back('{cycle, writes && dest != '0, dest, data});
        if (writes && dest != '0)
            refReg[dest] = data;
        instrValid = 1'b1;
        instr      = w;
        @(negedge Clk);
        instrValid = 1'b0;
    endtask

    task automatic rTypeInstr(input logic [5:0] op, input logic [5:0] fn,
                              input logic [4:0] rs, input logic [4:0] rt,
                              input logic [4:0] rd, input logic [4:0] sh);
        instrWord           w;
        logic signed [31:0] a;
        logic signed [31:0] b;
        logic signed [63:0] prod;
        logic [31:0]        res;
        logic               writes;
        w.rFields = '{op, rs, rt, rd, sh, fn};
        a         = refReg[rs];
        b         = refReg[rt];
        prod      = 64'(a) * 64'(b);
        res       = '0;
        writes    = (op == 6'h00);
        if (op == 6'h1C && fn == 6'h00)
            {refHi, refLo} = {refHi, refLo} + prod;  // madd
        else if (op == 6'h00)
        begin
            case (fn)
                6'h20:   res = a + b;
                6'h22:   res = a - b;
                6'h24:   res = a & b;
                6'h25:   res = a | b;
                6'h26:   res = a ^ b;
                6'h2A:   res = {31'b0, a < b};
                6'h00:   res = b << sh;
                6'h10:   res = refHi;
                6'h12:   res = refLo;
                6'h11:   refHi = a;
                6'h13:   refLo = a;
                6'h18:   {refHi, refLo} = prod;
                default: ;
            endcase
            if (!(fn inside {6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2A, 6'h00, 6'h10, 6'h12}))
                writes = 1'b0;
        end
        issueWord(w, writes, rd, res);
    endtask

    task automatic iTypeInstr(input logic [5:0] op, input logic [4:0] rs,
                              input logic [4:0] rt, input logic [15:0] imm);
        instrWord    w;
        logic [31:0] res;
        w.iFields = '{op, rs, rt, imm};
        case (op)
            6'h08:   res = refReg[rs] + {{16{imm[15]}}, imm};
            6'h0C:   res = refReg[rs] & {16'h0000, imm};
            6'h0D:   res = refReg[rs] | {16'h0000, imm};
            6'h0F:   res = {imm, 16'h0000};
            default: res = '0;
        endcase
        issueWord(w, op inside {6'h08, 6'h0C, 6'h0D, 6'h0F}, rt, res);
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge Clk);
    endtask

    task automatic drainAndReport(input string name, input int startErrors);
        int waited;
        waited = 0;
        while (expQ.size() > 0 && waited < 100)
        begin
            @(negedge Clk);
            waited++;
        end
        if (expQ.size() > 0)
        begin
            errors++;
            $display("Test %s timed out with %0d writebacks still pending", name, expQ.size());
            expQ.delete();
        end
        tests++;
        if (errors == startErrors)
            $display("Test %s: ok", name);
        else
        begin
            failedTests++;
            $display("Test %s: %0d errors", name, errors - startErrors);
        end
    endtask

    initial
    begin
        int         startErrors;
        logic [4:0] r;
        logic [4:0] prevRd;
        void'($urandom(21));
        Clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        refHi      = '0;
        refLo      = '0;
        for (int i = 0; i < `NUM_REGS; i++)
            refReg[i] = '0;
        repeat (4) @(negedge Clk);
        rstN = 1'b1;

        startErrors = errors;
        idle(2);
        rTypeInstr(6'h00, 6'h20, 5'd2, 5'd3, 5'd1, 5'd0);
        iTypeInstr(6'h0D, 5'd7, 5'd8, 16'h0000);
        drainAndReport("reset", startErrors);

        startErrors = errors;
        for (int i = 1; i < `NUM_REGS; i++)
            iTypeInstr(6'h0F, 5'd0, 5'(i), 16'($urandom));
        idle(1);
        for (int i = 1; i < `NUM_REGS; i++)
            iTypeInstr(6'h0D, 5'(i), 5'(i), 16'($urandom));
        for (int k = 0; k < 12; k++)
        begin
            idle(1);
            r = 5'(1 + $urandom % 31);
            iTypeInstr(6'h08, r, r, (k % 2 == 1) ? (16'h8000 | 16'($urandom))
                                                 : (16'h7FFF & 16'($urandom)));
            idle(1);
            iTypeInstr(6'h0C, r, 5'(1 + $urandom % 31), 16'($urandom));
        end
        drainAndReport("itype", startErrors);

        startErrors = errors;
        for (int k = 0; k < 21; k++)  // Independent, back to back.
            rTypeInstr(6'h00, aluFunct(k), srcReg(), srcReg(), dstReg(), 5'($urandom));
        prevRd = dstReg();
        rTypeInstr(6'h00, 6'h20, srcReg(), srcReg(), prevRd, 5'd0);
        for (int k = 0; k < 7; k++)
        begin
            idle(1);  // Dependent pair, read through the bypass.
            r = 5'(1 + $urandom % 31);
            rTypeInstr(6'h00, aluFunct(k), prevRd, srcReg(), r, 5'($urandom));
            prevRd = r;
        end
        drainAndReport("rtype", startErrors);

        startErrors = errors;
        for (int k = 0; k < 6; k++)
        begin
            rTypeInstr(6'h00, 6'h18, srcReg(), srcReg(), 5'd0, 5'd0);
            rTypeInstr(6'h00, 6'h10, 5'd0, 5'd0, dstReg(), 5'd0);  // mfhi right after mult.
            rTypeInstr(6'h00, 6'h12, 5'd0, 5'd0, dstReg(), 5'd0);
            rTypeInstr(6'h1C, 6'h00, srcReg(), srcReg(), 5'd0, 5'd0);
            rTypeInstr(6'h00, 6'h10, 5'd0, 5'd0, dstReg(), 5'd0);
            rTypeInstr(6'h00, 6'h11, srcReg(), 5'd0, 5'd0, 5'd0);
            rTypeInstr(6'h00, 6'h13, srcReg(), 5'd0, 5'd0, 5'd0);
            rTypeInstr(6'h00, 6'h12, 5'd0, 5'd0, dstReg(), 5'd0);
        end
        drainAndReport("hilo", startErrors);

        startErrors = errors;
        iTypeInstr(6'h08, 5'd5, 5'd0, 16'h1234);
        rTypeInstr(6'h00, 6'h20, 5'd1, 5'd2, 5'd0, 5'd0);
        iTypeInstr(6'h3F, 5'd1, 5'd7, 16'hFFFF);  // Unknown opcode.
        rTypeInstr(6'h00, 6'h3F, 5'd1, 5'd2, 5'd7, 5'd0);
        idle(1);
        rTypeInstr(6'h00, 6'h25, 5'd0, 5'd0, 5'd9, 5'd0);
        iTypeInstr(6'h0D, 5'd0, 5'd11, 16'h0000);
        drainAndReport("zero", startErrors);

        startErrors = errors;
        for (int k = 0; k < 24; k++)
        begin
            if ($urandom % 2 == 0)
                rTypeInstr(6'h00, aluFunct(k), srcReg(), srcReg(), dstReg(), 5'($urandom));
            else
                iTypeInstr(6'h0D, srcReg(), dstReg(), 16'($urandom));
            idle(int'($urandom % 4));
        end
        drainAndReport("gaps", startErrors);

        $display("Tests run %0d, failed %0d, check errors %0d", tests, failedTests, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: execPipeTop.f
+incdir+src
src/cpuPkg.sv
src/regFile.sv
src/decodeStage.sv
src/idExPipeReg.sv
src/executeStage.sv
src/execPipeTop.sv
testbench/execPipeTb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and scan the log.
LOG=sim.log

verilator --binary --assert --top-module execPipeTb -f execPipeTop.f --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "** FAIL **" "$LOG"; then
    exit 1
fi
exit 0
